//--- Makefile
# Verilator build for the xlat translation check stage

VERILATOR ?= verilator
TOP       ?= xlat_tb
FILELIST  ?= xlat.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') xlat_params.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- xlat.f
+incdir+.
xlat_pkg.sv
xlat_tlb.sv
xlat_pagefault.sv
xlat_ctrl.sv
xlat_top.sv
xlat_assert.sv
xlat_tb.sv

//--- xlat_assert.sv
/*
 * xlat control assertions
 * timing rules of the control FSM bound into every xlat_ctrl
 */

`default_nettype none
`timescale 1ns/10ps

module xlat_assert (
    input  wire                     clk,
    input  wire                     arst_n,
    input  xlat_pkg::ctrl_state_e   state,
    input  wire                     busy,
    input  wire                     lookup,
    input  wire                     done
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    // done comes two cycles after the lookup pulse
    done_after_lookup: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $past(lookup, 2))
        else $error("done without a lookup two cycles earlier");

    // busy only drops in the cycle that done rises
    busy_ends_with_done: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> done)
        else $error("busy dropped without done");

    // lookup only ever seen in its own state
    lookup_in_state: assert property (@(posedge clk) disable iff (!arst_n)
        lookup |-> (state == xlat_pkg::st_lookup))
        else $error("lookup outside the lookup state");

endmodule

bind xlat_ctrl xlat_assert xlat_assert_i (
    .clk    (clk),
    .arst_n (arst_n),
    .state  (state),
    .busy   (busy),
    .lookup (lookup),
    .done   (done)
);

`default_nettype wire

//--- xlat_ctrl.sv
/*
 * xlat control
 * accepts one request at a time, drives the TLB lookup and merges
 * bypass, hit and permission results into the registered response;
 * done follows an accepted request by two cycles
 */

`default_nettype none
`timescale 1ns/10ps

`include "xlat_params.svh"

module xlat_ctrl (
    input  wire                             clk,
    input  wire                             arst_n,
    // request strobe
    input  wire                             req,
    input  xlat_pkg::cmd_e                  req_cmd,
    input  wire [`XLAT_VA_WIDTH-1:0]        req_vaddr,
    // checker and TLB results
    input  wire                             translate,
    input  wire                             hit,
    input  wire [`XLAT_PPN_WIDTH-1:0]       hit_ppn,
    input  wire                             pagefault,
    input  xlat_pkg::fault_cause_e          cause,
    // status and latched request
    output logic                            busy,
    output logic                            done,
    output xlat_pkg::cmd_e                  cmd,
    output logic                            lookup,
    output logic [`XLAT_VPN_WIDTH-1:0]      lookup_vpn,
    // response, held until the next done
    output logic                            resp_miss,
    output logic                            resp_fault,
    output xlat_pkg::fault_cause_e          resp_cause,
    output logic [`XLAT_PA_WIDTH-1:0]       resp_paddr
);

    xlat_pkg::ctrl_state_e state;
    logic [`XLAT_VA_WIDTH-1:0] vaddr;
    logic accept;

    // new request only taken when idle, others are dropped
    assign accept     = (state == xlat_pkg::st_idle) && req;
    assign busy       = (state != xlat_pkg::st_idle);
    assign lookup_vpn = vaddr[`XLAT_VA_WIDTH-1:`XLAT_OFFSET_WIDTH];

    ////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= xlat_pkg::st_idle;
            lookup     <= 1'b0;
            done       <= 1'b0;
            resp_miss  <= 1'b0;
            resp_fault <= 1'b0;
            resp_cause <= xlat_pkg::cause_none;
            resp_paddr <= '0;
        end else begin
            // strobes default low
            lookup <= 1'b0;
            done   <= 1'b0;
            case (state)
                xlat_pkg::st_idle: begin
                    if (accept) begin
                        state  <= xlat_pkg::st_lookup;
                        lookup <= 1'b1;
                    end
                end
                // tlb registers its result on this edge
                xlat_pkg::st_lookup: begin
                    state <= xlat_pkg::st_resp;
                end
                xlat_pkg::st_resp: begin
                    state <= xlat_pkg::st_idle;
                    done  <= 1'b1;
                    if (!translate) begin
                        // bypass, physical = zero-extended virtual
                        resp_miss  <= 1'b0;
                        resp_fault <= 1'b0;
                        resp_cause <= xlat_pkg::cause_none;
                        resp_paddr <= {{(`XLAT_PA_WIDTH - `XLAT_VA_WIDTH){1'b0}}, vaddr};
                    end else if (!hit) begin
                        // no entry, left to software refill
                        resp_miss  <= 1'b1;
                        resp_fault <= 1'b0;
                        resp_cause <= xlat_pkg::cause_none;
                        resp_paddr <= '0;
                    end else begin
                        resp_miss  <= 1'b0;
                        resp_fault <= pagefault;
                        resp_cause <= cause;
                        resp_paddr <= {hit_ppn, vaddr[`XLAT_OFFSET_WIDTH-1:0]};
                    end
                end
                default: begin
                    state <= xlat_pkg::st_idle;
                end
            endcase
        end
    end

    // request latch, feeds the lookup and the checker
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd   <= req_cmd;
            vaddr <= req_vaddr;
        end
    end

endmodule

`default_nettype wire

//--- xlat_pagefault.sv
/*
 * xlat page fault checker
 * resolves the effective privilege from the machine CSR fields,
 * decides whether the access is translated at all, and checks the
 * page metadata of a TLB hit against the command; purely combinational
 */

`default_nettype none
`timescale 1ns/10ps

`include "xlat_params.svh"

module xlat_pagefault (
    input  xlat_pkg::cmd_e                  cmd,
    input  wire [`XLAT_META_WIDTH-1:0]      meta,
    // CSR levels, stable while a request is in flight
    input  wire                             satp_mode,
    input  xlat_pkg::priv_e                 cur_priv,
    input  wire                             mprv,
    input  xlat_pkg::priv_e                 mpp,
    input  wire                             mxr,
    input  wire                             sum,
    // check result
    output logic                            translate,
    output logic                            pagefault,
    output xlat_pkg::fault_cause_e          cause
);

    // metadata flags
    logic m_v;
    logic m_r;
    logic m_w;
    logic m_x;
    logic m_u;
    logic m_a;
    logic m_d;

    xlat_pkg::priv_e eff_priv;

    assign m_v = meta[`XLAT_META_V];
    assign m_r = meta[`XLAT_META_R];
    assign m_w = meta[`XLAT_META_W];
    assign m_x = meta[`XLAT_META_X];
    assign m_u = meta[`XLAT_META_U];
    assign m_a = meta[`XLAT_META_A];
    assign m_d = meta[`XLAT_META_D];

    ////////////////////////////////////////////////
    // privilege and bypass
    ////////////////////////////////////////////////

    // mprv makes machine-mode data accesses use mpp
    assign eff_priv = (cur_priv == xlat_pkg::priv_machine && mprv) ? mpp : cur_priv;

    // machine mode or bare satp means physical access
    assign translate = (eff_priv != xlat_pkg::priv_machine) && satp_mode;

    ////////////////////////////////////////////////
    // permission rules
    ////////////////////////////////////////////////

    // later rules overwrite cause, so the last one that applies is reported
    always_comb begin
        pagefault = 1'b0;
        cause     = xlat_pkg::cause_none;
        if (translate) begin
            // pte must be valid and either readable or executable
            if (!m_v || (!m_r && !m_x)) begin
                pagefault = 1'b1;
                cause     = xlat_pkg::cause_invalid;
            end
            // supervisor touching a user page without sum
            if (eff_priv == xlat_pkg::priv_supervisor) begin
                if (m_u && !sum) begin
                    pagefault = 1'b1;
                    cause     = xlat_pkg::cause_sup_user;
                end
            end else if (eff_priv == xlat_pkg::priv_user) begin
                // user touching a supervisor page
                if (!m_u) begin
                    pagefault = 1'b1;
                    cause     = xlat_pkg::cause_user_page;
                end
            end
            // accessed flag first, then the command specific checks
            if (!m_a) begin
                pagefault = 1'b1;
                cause     = xlat_pkg::cause_access;
            end else if (cmd == xlat_pkg::cmd_store || cmd == xlat_pkg::cmd_store_cond) begin
                if (!m_d) begin
                    pagefault = 1'b1;
                    cause     = xlat_pkg::cause_dirty;
                end else if (!m_w) begin
                    pagefault = 1'b1;
                    cause     = xlat_pkg::cause_unwritable;
                end
            end else if (cmd == xlat_pkg::cmd_load || cmd == xlat_pkg::cmd_load_reserve) begin
                // mxr lets loads read execute-only pages
                if (!m_r && !(mxr && m_x)) begin
                    pagefault = 1'b1;
                    cause     = xlat_pkg::cause_load_unreadable;
                end
            end else if (cmd == xlat_pkg::cmd_execute) begin
                if (!m_x) begin
                    pagefault = 1'b1;
                    cause     = xlat_pkg::cause_exec;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- xlat_params.svh
/*
 * xlat parameters
 * address widths, TLB geometry and Sv32 PTE metadata bit positions
 */

`ifndef XLAT_PARAMS_SVH
`define XLAT_PARAMS_SVH

// address split, 4 KiB pages
`define XLAT_VA_WIDTH       32
`define XLAT_PA_WIDTH       34
`define XLAT_OFFSET_WIDTH   12
`define XLAT_VPN_WIDTH      20
`define XLAT_PPN_WIDTH      22

// tlb geometry, 8 or 16 entries also work
`define XLAT_TLB_ENTRIES    4
`define XLAT_TLB_IDX_WIDTH  $clog2(`XLAT_TLB_ENTRIES)

// page metadata, same layout as the low byte of an Sv32 PTE
`define XLAT_META_WIDTH     8
`define XLAT_META_V         0
`define XLAT_META_R         1
`define XLAT_META_W         2
`define XLAT_META_X         3
`define XLAT_META_U         4
// bit 5 is the global flag, not used here
`define XLAT_META_A         6
`define XLAT_META_D         7

`endif

//--- xlat_pkg.sv
/*
 * xlat package
 * shared enum types for the Sv32 address-translation check stage:
 * privilege levels, memory commands, control FSM states and the
 * page fault cause reported with each response
 */

`default_nettype none

package xlat_pkg;

    // privilege encoding as in the RISC-V mstatus/mpp fields
    typedef enum logic [1:0] {
        priv_user       = 2'd0,
        priv_supervisor = 2'd1,
        priv_machine    = 2'd3
    } priv_e;

    // command carried with each request
    typedef enum logic [2:0] {
        cmd_none,
        cmd_load,
        cmd_load_reserve,
        cmd_store,
        cmd_store_cond,
        cmd_execute
    } cmd_e;

    // control FSM states
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_resp
    } ctrl_state_e;

    // page fault cause, ordered as the checker evaluates the rules
    typedef enum logic [3:0] {
        cause_none,
        cause_invalid,
        cause_sup_user,
        cause_user_page,
        cause_access,
        cause_dirty,
        cause_unwritable,
        cause_load_unreadable,
        cause_exec
    } fault_cause_e;

endpackage

`default_nettype wire

//--- xlat_tb.sv
/*
 * xlat testbench
 * table-driven checks of bypass, miss, flush, permission causes and
 * CSR modifiers, then a random mix compared against a rule model;
 * also checks request-to-done timing and response hold
 */

`default_nettype none
`timescale 1ns/10ps

`include "xlat_params.svh"

module xlat_tb;

    localparam int ROWS = 20;
    localparam int DONE_TIMEOUT = 20;
    localparam logic [19:0] T_VPN = 20'h00040;
    localparam logic [21:0] T_PPN = 22'h2abcd;

    logic                           clk;
    logic                           arst_n;
    logic                           req;
    xlat_pkg::cmd_e                 req_cmd;
    logic [`XLAT_VA_WIDTH-1:0]      req_vaddr;
    logic                           satp_mode;
    xlat_pkg::priv_e                cur_priv;
    logic                           mprv;
    xlat_pkg::priv_e                mpp;
    logic                           mxr;
    logic                           sum;
    logic                           tlb_wr;
    logic [`XLAT_TLB_IDX_WIDTH-1:0] tlb_wr_idx;
    logic [`XLAT_VPN_WIDTH-1:0]     tlb_wr_vpn;
    logic [`XLAT_PPN_WIDTH-1:0]     tlb_wr_ppn;
    logic [`XLAT_META_WIDTH-1:0]    tlb_wr_meta;
    logic                           tlb_flush;
    logic                           busy;
    logic                           done;
    logic                           resp_miss;
    logic                           resp_fault;
    xlat_pkg::fault_cause_e         resp_cause;
    logic [`XLAT_PA_WIDTH-1:0]      resp_paddr;

    // stimulus table with one request per row
    logic        t_flush [ROWS];
    logic        t_wr    [ROWS];
    logic [7:0]  t_meta  [ROWS];
    logic [2:0]  t_cmd   [ROWS];
    logic [31:0] t_vaddr [ROWS];
    logic [6:0]  t_csr   [ROWS];
    logic [5:0]  t_exp   [ROWS];
    logic [33:0] t_paddr [ROWS];
    int          n_rows;

    // last response which must hold until the next done
    logic        have_resp;
    logic [39:0] last_resp;

    // copy of the TLB contents for the random phase
    logic [19:0] m_vpn  [4];
    logic [21:0] m_ppn  [4];
    logic [7:0]  m_meta [4];

    integer seed;

    xlat_top xlat_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .req_cmd     (req_cmd),
        .req_vaddr   (req_vaddr),
        .satp_mode   (satp_mode),
        .cur_priv    (cur_priv),
        .mprv        (mprv),
        .mpp         (mpp),
        .mxr         (mxr),
        .sum         (sum),
        .tlb_wr      (tlb_wr),
        .tlb_wr_idx  (tlb_wr_idx),
        .tlb_wr_vpn  (tlb_wr_vpn),
        .tlb_wr_ppn  (tlb_wr_ppn),
        .tlb_wr_meta (tlb_wr_meta),
        .tlb_flush   (tlb_flush),
        .busy        (busy),
        .done        (done),
        .resp_miss   (resp_miss),
        .resp_fault  (resp_fault),
        .resp_cause  (resp_cause),
        .resp_paddr  (resp_paddr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // csr packed as {satp, priv[1:0], mprv, mpp[1:0], mxr} plus sum in the row
    task automatic add_row(input logic fl, input logic wr, input logic [7:0] meta,
                           input logic [2:0] c, input logic [31:0] va,
                           input logic [6:0] csr, input logic [5:0] exp,
                           input logic [33:0] pa);
        t_flush[n_rows] = fl;
        t_wr[n_rows]    = wr;
        t_meta[n_rows]  = meta;
        t_cmd[n_rows]   = c;
        t_vaddr[n_rows] = va;
        t_csr[n_rows]   = csr;
        t_exp[n_rows]   = exp;
        t_paddr[n_rows] = pa;
        n_rows++;
    endtask

    task automatic write_tlb(input logic [1:0] idx, input logic [19:0] vpn,
                             input logic [21:0] ppn, input logic [7:0] meta);
        @(posedge clk);
        tlb_wr      <= 1'b1;
        tlb_wr_idx  <= idx;
        tlb_wr_vpn  <= vpn;
        tlb_wr_ppn  <= ppn;
        tlb_wr_meta <= meta;
        @(posedge clk);
        tlb_wr      <= 1'b0;
    endtask

    task automatic flush_tlb();
        @(posedge clk);
        tlb_flush <= 1'b1;
        @(posedge clk);
        tlb_flush <= 1'b0;
    endtask

    // rule model returning {translate, fault, cause}
    function automatic logic [5:0] model_rules(input logic [2:0] c, input logic [7:0] m,
                                               input logic [6:0] csr, input logic sm);
        logic [1:0] ep;
        logic       tr;
        logic       f;
        logic [3:0] cs;
        logic       is_st;
        logic       is_ld;
        ep = (csr[5:4] == 2'd3 && csr[3]) ? csr[2:1] : csr[5:4];
        tr = csr[6] && (ep != 2'd3);
        f = 1'b0;
        cs = 4'd0;
        is_st = (c == 3'd3) || (c == 3'd4);
        is_ld = (c == 3'd1) || (c == 3'd2);
        if (tr) begin
            if (!m[0] || (!m[1] && !m[3])) begin
                f = 1'b1;
                cs = 4'd1;
            end
            if (ep == 2'd1 && m[4] && !sm) begin
                f = 1'b1;
                cs = 4'd2;
            end
            if (ep == 2'd0 && !m[4]) begin
                f = 1'b1;
                cs = 4'd3;
            end
            if (!m[6]) begin
                f = 1'b1;
                cs = 4'd4;
            end else if (is_st && !m[7]) begin
                f = 1'b1;
                cs = 4'd5;
            end else if (is_st && !m[2]) begin
                f = 1'b1;
                cs = 4'd6;
            end else if (is_ld && !m[1] && !(csr[0] && m[3])) begin
                f = 1'b1;
                cs = 4'd7;
            end else if (c == 3'd5 && !m[3]) begin
                f = 1'b1;
                cs = 4'd8;
            end
        end
        return {tr, f, cs};
    endfunction

    // issue one request and wait for its done pulse
    task automatic run_request(input logic [2:0] c, input logic [31:0] va,
                               input logic [6:0] csr, input logic sm);
        int cycles;
        if (have_resp) begin
            check("held_response", {resp_miss, resp_fault, resp_cause, resp_paddr}, last_resp);
        end
        @(posedge clk);
        req       <= 1'b1;
        req_cmd   <= xlat_pkg::cmd_e'(c);
        req_vaddr <= va;
        satp_mode <= csr[6];
        cur_priv  <= xlat_pkg::priv_e'(csr[5:4]);
        mprv      <= csr[3];
        mpp       <= xlat_pkg::priv_e'(csr[2:1]);
        mxr       <= csr[0];
        sum       <= sm;
        @(posedge clk);
        req <= 1'b0;
        // accepted on this edge so done shows on the third falling edge
        cycles = 0;
        while (1) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                break;
            end
            check("busy", busy, 1);
            if (have_resp) begin
                check("held_response", {resp_miss, resp_fault, resp_cause, resp_paddr},
                      last_resp);
            end
            if (cycles >= DONE_TIMEOUT) begin
                $display("timeout waiting for done after a request");
                $display("RESULT: FAIL");
                $fatal(1, "no done");
            end
        end
        check("done_latency", cycles, 3);
        check("busy_at_done", busy, 0);
        last_resp = {resp_miss, resp_fault, resp_cause, resp_paddr};
        have_resp = 1'b1;
    endtask

    ////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////

    initial begin
        logic [5:0]  exp;
        logic [2:0]  c;
        logic [31:0] va;
        logic [6:0]  csr;
        logic        sm;
        logic [33:0] pa;
        logic        miss;
        int          sel;
        arst_n      = 1'b0;
        req         = 1'b0;
        req_cmd     = xlat_pkg::cmd_none;
        req_vaddr   = '0;
        satp_mode   = 1'b0;
        cur_priv    = xlat_pkg::priv_machine;
        mprv        = 1'b0;
        mpp         = xlat_pkg::priv_user;
        mxr         = 1'b0;
        sum         = 1'b0;
        tlb_wr      = 1'b0;
        tlb_wr_idx  = '0;
        tlb_wr_vpn  = '0;
        tlb_wr_ppn  = '0;
        tlb_wr_meta = '0;
        tlb_flush   = 1'b0;
        have_resp   = 1'b0;
        seed        = 32'hc027;
        n_rows      = 0;

        // exp is {miss, fault, cause}; cause 1 invalid .. 8 exec
        // csr {satp, priv, mprv, mpp, mxr}; meta V01 R02 W04 X08 U10 A40 D80
        add_row(0, 0, 8'h00, 1, 32'hdeadbeef, 7'b1_11_0_00_0, 6'h00, 34'h0deadbeef);
        add_row(0, 0, 8'h00, 3, 32'h80000123, 7'b0_01_0_00_0, 6'h00, 34'h080000123);
        add_row(0, 0, 8'h00, 5, 32'h12345678, 7'b1_11_1_11_0, 6'h00, 34'h012345678);
        add_row(0, 0, 8'h00, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h20, 34'h0);
        add_row(0, 1, 8'hcf, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h00, 34'h2abcdabc);
        add_row(1, 0, 8'h00, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h20, 34'h0);
        add_row(0, 1, 8'hc2, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h11, 34'h2abcdabc);
        add_row(0, 1, 8'hd3, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h12, 34'h2abcdabc);
        add_row(0, 1, 8'hc3, 1, 32'h00040abc, 7'b1_00_0_00_0, 6'h13, 34'h2abcdabc);
        add_row(0, 1, 8'h93, 1, 32'h00040abc, 7'b1_00_0_00_0, 6'h14, 34'h2abcdabc);
        add_row(0, 1, 8'h57, 3, 32'h00040abc, 7'b1_00_0_00_0, 6'h15, 34'h2abcdabc);
        add_row(0, 1, 8'hd3, 4, 32'h00040abc, 7'b1_00_0_00_0, 6'h16, 34'h2abcdabc);
        add_row(0, 1, 8'hd9, 1, 32'h00040abc, 7'b1_00_0_00_0, 6'h17, 34'h2abcdabc);
        add_row(0, 1, 8'hd3, 5, 32'h00040abc, 7'b1_00_0_00_0, 6'h18, 34'h2abcdabc);
        // several rules apply and the last one wins
        add_row(0, 1, 8'h10, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h14, 34'h2abcdabc);
        add_row(0, 1, 8'hc0, 3, 32'h00040abc, 7'b1_00_0_00_0, 6'h16, 34'h2abcdabc);
        // csr modifiers with sum set on row 16 only
        add_row(0, 1, 8'hd3, 1, 32'h00040abc, 7'b1_01_0_00_0, 6'h00, 34'h2abcdabc);
        add_row(0, 1, 8'hd9, 2, 32'h00040abc, 7'b1_00_0_00_1, 6'h00, 34'h2abcdabc);
        add_row(0, 1, 8'hc3, 1, 32'h00040abc, 7'b1_11_1_00_0, 6'h13, 34'h2abcdabc);
        add_row(0, 1, 8'hd3, 1, 32'h00040abc, 7'b1_11_1_00_0, 6'h00, 34'h2abcdabc);

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("busy_after_reset", busy, 0);
        check("done_after_reset", done, 0);

        for (int i = 0; i < n_rows; i++) begin
            if (t_flush[i]) begin
                flush_tlb();
            end
            if (t_wr[i]) begin
                write_tlb(2'd3, T_VPN, T_PPN, t_meta[i]);
            end
            run_request(t_cmd[i], t_vaddr[i], t_csr[i], (i == 16));
            check("resp_miss", resp_miss, t_exp[i][5]);
            check("resp_fault", resp_fault, t_exp[i][4]);
            check("resp_cause", resp_cause, t_exp[i][3:0]);
            check("resp_paddr", resp_paddr, t_paddr[i]);
        end

        ////////////////////////////////////////////////////
        // random mix
        ////////////////////////////////////////////////////

        flush_tlb();
        for (int e = 0; e < 4; e++) begin
            m_vpn[e]  = 20'h00100 + 20'($unsigned($random(seed)) % 8);
            m_ppn[e]  = 22'($random(seed));
            m_meta[e] = 8'($random(seed));
            write_tlb(2'(e), m_vpn[e], m_ppn[e], m_meta[e]);
        end
        for (int n = 0; n < 40; n++) begin
            c = 3'(1 + $unsigned($random(seed)) % 5);
            va = {20'h00100 + 20'($unsigned($random(seed)) % 8), 12'($random(seed))};
            csr = 7'($random(seed));
            if (csr[5:4] == 2'd2) begin
                csr[5:4] = 2'd1;
            end
            if (csr[2:1] == 2'd2) begin
                csr[2:1] = 2'd0;
            end
            sm = 1'($random(seed));
            // lowest matching entry wins
            sel = -1;
            for (int e = 3; e >= 0; e--) begin
                if (m_vpn[e] == va[31:12]) begin
                    sel = e;
                end
            end
            exp = model_rules(c, (sel >= 0) ? m_meta[sel] : 8'h00, csr, sm);
            miss = exp[5] && (sel < 0);
            if (!exp[5]) begin
                pa = {2'b00, va};
            end else if (miss) begin
                pa = '0;
            end else begin
                pa = {m_ppn[sel], va[11:0]};
            end
            run_request(c, va, csr, sm);
            check("rand_resp_miss", resp_miss, miss);
            check("rand_resp_fault", resp_fault, miss ? 1'b0 : exp[4]);
            check("rand_resp_cause", resp_cause, miss ? 4'd0 : exp[3:0]);
            check("rand_resp_paddr", resp_paddr, pa);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- xlat_tlb.sv
/*
 * xlat TLB
 * small fully associative TLB holding VPN, PPN and page metadata;
 * software fills entries through the write port and clears all
 * valid flags with flush; a lookup compares every valid entry in
 * parallel and registers the lowest matching entry one cycle later
 */

`default_nettype none
`timescale 1ns/10ps

`include "xlat_params.svh"

module xlat_tlb (
    input  wire                             clk,
    input  wire                             arst_n,
    // software maintenance port
    input  wire                             flush,
    input  wire                             wr,
    input  wire [`XLAT_TLB_IDX_WIDTH-1:0]   wr_idx,
    input  wire [`XLAT_VPN_WIDTH-1:0]       wr_vpn,
    input  wire [`XLAT_PPN_WIDTH-1:0]       wr_ppn,
    input  wire [`XLAT_META_WIDTH-1:0]      wr_meta,
    // lookup request from the control FSM
    input  wire                             lookup,
    input  wire [`XLAT_VPN_WIDTH-1:0]       lookup_vpn,
    // registered lookup result
    output logic                            hit,
    output logic [`XLAT_PPN_WIDTH-1:0]      hit_ppn,
    output logic [`XLAT_META_WIDTH-1:0]     hit_meta
);

    ////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////

    logic [`XLAT_TLB_ENTRIES-1:0]   valid;
    logic [`XLAT_VPN_WIDTH-1:0]     vpn_tab  [`XLAT_TLB_ENTRIES];
    logic [`XLAT_PPN_WIDTH-1:0]     ppn_tab  [`XLAT_TLB_ENTRIES];
    logic [`XLAT_META_WIDTH-1:0]    meta_tab [`XLAT_TLB_ENTRIES];

    // per-entry compare and the selected entry
    logic [`XLAT_TLB_ENTRIES-1:0]   match;
    logic                           match_any;
    logic [`XLAT_PPN_WIDTH-1:0]     sel_ppn;
    logic [`XLAT_META_WIDTH-1:0]    sel_meta;

    // valid flags
    // flush is applied before the write so a write in the same cycle survives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else begin
            if (flush) begin
                valid <= '0;
            end
            if (wr) begin
                valid[wr_idx] <= 1'b1;
            end
        end
    end

    // entry contents
    always_ff @(posedge clk) begin
        if (wr) begin
            vpn_tab[wr_idx]  <= wr_vpn;
            ppn_tab[wr_idx]  <= wr_ppn;
            meta_tab[wr_idx] <= wr_meta;
        end
    end

    ////////////////////////////////////////////////
    // parallel compare
    ////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `XLAT_TLB_ENTRIES; i++) begin
            match[i] = valid[i] && (vpn_tab[i] == lookup_vpn);
        end
    end

    // walk from the top so the lowest matching index wins
    always_comb begin
        match_any = 1'b0;
        sel_ppn   = '0;
        sel_meta  = '0;
        for (int i = `XLAT_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                match_any = 1'b1;
                sel_ppn   = ppn_tab[i];
                sel_meta  = meta_tab[i];
            end
        end
    end

    ////////////////////////////////////////////////
    // registered result
    ////////////////////////////////////////////////

    // hit holds until the next lookup
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit <= 1'b0;
        end else if (lookup) begin
            hit <= match_any;
        end
    end

    // translation payload, captured with hit
    always_ff @(posedge clk) begin
        if (lookup) begin
            hit_ppn  <= sel_ppn;
            hit_meta <= sel_meta;
        end
    end

endmodule

`default_nettype wire

//--- xlat_top.sv
/*
 * xlat top
 * Sv32 translation check stage: control FSM, TLB and page fault
 * checker wired together; a request returns a physical address,
 * a miss, or a page fault with its cause
 */

`default_nettype none
`timescale 1ns/10ps

`include "xlat_params.svh"

module xlat_top (
    input  wire                             clk,
    input  wire                             arst_n,
    // request
    input  wire                             req,
    input  xlat_pkg::cmd_e                  req_cmd,
    input  wire [`XLAT_VA_WIDTH-1:0]        req_vaddr,
    // CSR levels
    input  wire                             satp_mode,
    input  xlat_pkg::priv_e                 cur_priv,
    input  wire                             mprv,
    input  xlat_pkg::priv_e                 mpp,
    input  wire                             mxr,
    input  wire                             sum,
    // TLB maintenance, only while idle
    input  wire                             tlb_wr,
    input  wire [`XLAT_TLB_IDX_WIDTH-1:0]   tlb_wr_idx,
    input  wire [`XLAT_VPN_WIDTH-1:0]       tlb_wr_vpn,
    input  wire [`XLAT_PPN_WIDTH-1:0]       tlb_wr_ppn,
    input  wire [`XLAT_META_WIDTH-1:0]      tlb_wr_meta,
    input  wire                             tlb_flush,
    // status and response
    output wire                             busy,
    output wire                             done,
    output wire                             resp_miss,
    output wire                             resp_fault,
    output xlat_pkg::fault_cause_e          resp_cause,
    output wire [`XLAT_PA_WIDTH-1:0]        resp_paddr
);

    ////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////

    xlat_pkg::cmd_e                 cmd;
    wire                            lookup;
    wire [`XLAT_VPN_WIDTH-1:0]      lookup_vpn;
    wire                            hit;
    wire [`XLAT_PPN_WIDTH-1:0]      hit_ppn;
    wire [`XLAT_META_WIDTH-1:0]     hit_meta;
    wire                            translate;
    wire                            pagefault;
    xlat_pkg::fault_cause_e         cause;

    // request sequencing and response merge
    xlat_ctrl xlat_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_cmd    (req_cmd),
        .req_vaddr  (req_vaddr),
        .translate  (translate),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .pagefault  (pagefault),
        .cause      (cause),
        .busy       (busy),
        .done       (done),
        .cmd        (cmd),
        .lookup     (lookup),
        .lookup_vpn (lookup_vpn),
        .resp_miss  (resp_miss),
        .resp_fault (resp_fault),
        .resp_cause (resp_cause),
        .resp_paddr (resp_paddr)
    );

    // page table cache
    xlat_tlb xlat_tlb_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (tlb_flush),
        .wr         (tlb_wr),
        .wr_idx     (tlb_wr_idx),
        .wr_vpn     (tlb_wr_vpn),
        .wr_ppn     (tlb_wr_ppn),
        .wr_meta    (tlb_wr_meta),
        .lookup     (lookup),
        .lookup_vpn (lookup_vpn),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .hit_meta   (hit_meta)
    );

    // permission check on the registered hit metadata
    xlat_pagefault xlat_pagefault_i (
        .cmd        (cmd),
        .meta       (hit_meta),
        .satp_mode  (satp_mode),
        .cur_priv   (cur_priv),
        .mprv       (mprv),
        .mpp        (mpp),
        .mxr        (mxr),
        .sum        (sum),
        .translate  (translate),
        .pagefault  (pagefault),
        .cause      (cause)
    );

endmodule

`default_nettype wire
